// ==== source/ecc_pkg.sv ====
package ecc_pkg;

    // code geometry of the 65-bit SECDED code.
    localparam int DATA_W   = 65;
    localparam int PARITY_W = 8;

    // a stored word keeps the check bits above the data bits.
    localparam int CODE_W   = DATA_W + PARITY_W;

    // width of each error counter in the log.
    localparam int COUNT_W  = 16;

    // background scrubber steps.
    typedef enum logic [1:0] {
        S_READ  = 2'd0,
        S_CHECK = 2'd1,
        S_FIX   = 2'd2
    } scrub_state_t;

endpackage

// ==== source/ecc_65_cal.sv ====
`timescale 1ns/1ns

module ecc_65_cal
    import ecc_pkg::*;
(
    input  logic [DATA_W-1:0]   data_in,
    input  logic [PARITY_W-1:0] parity_in,
    input  logic                bypass,
    output logic [DATA_W-1:0]   data_out,
    output logic [PARITY_W-1:0] parity_out,
    output logic [DATA_W-1:0]   mask,
    output logic                sbit_err,
    output logic                dbit_err
);

    // check matrix columns, one byte per data bit, data bit 64 first.
    // each byte lists the check bits that cover that data bit.
    localparam logic [DATA_W*PARITY_W-1:0] H_COLS = {
        8'hC8, 8'hC7, 8'h46, 8'h45, 8'hC4, 8'h43, 8'hC2, 8'hC1,
        8'hBF, 8'h3E, 8'h3D, 8'hBC, 8'h3B, 8'hBA, 8'hB9, 8'h38,
        8'h37, 8'hB6, 8'hB5, 8'h34, 8'hB3, 8'h32, 8'h31, 8'hB0,
        8'h2F, 8'hAE, 8'hAD, 8'h2C, 8'hAB, 8'h2A, 8'h29, 8'hA8,
        8'hA7, 8'h26, 8'h25, 8'hA4, 8'h23, 8'hA2, 8'hA1, 8'h1F,
        8'h9E, 8'h9D, 8'h1C, 8'h9B, 8'h1A, 8'h19, 8'h98, 8'h97,
        8'h16, 8'h15, 8'h94, 8'h13, 8'h92, 8'h91, 8'h8F, 8'h0E,
        8'h0D, 8'h8C, 8'h0B, 8'h8A, 8'h89, 8'h07, 8'h86, 8'h85,
        8'h83
    };

    logic [PARITY_W-1:0] syndrome;
    logic [PARITY_W-1:0] syndrome_m1;
    logic                parity_bit_err;
    logic                single_err;
    logic                double_err;

    // check bits are the XOR of the columns of all set data bits.
    always_comb begin
        parity_out = '0;
        for (int i = 0; i < DATA_W; i++) begin
            parity_out = parity_out
                       ^ ({PARITY_W{data_in[i]}} & H_COLS[i*PARITY_W +: PARITY_W]);
        end
    end

    assign syndrome    = parity_in ^ parity_out;
    assign syndrome_m1 = syndrome - 1'b1;

    // a syndrome equal to a column points at the data bit to flip.
    always_comb begin
        mask = '0;
        for (int i = 0; i < DATA_W; i++) begin
            mask[i] = (syndrome == H_COLS[i*PARITY_W +: PARITY_W]);
        end
    end

    // a one-hot syndrome means a flipped check bit, the data is intact.
    assign parity_bit_err = (syndrome != '0) && ((syndrome & syndrome_m1) == '0);

    assign single_err = (|mask) || parity_bit_err;
    assign double_err = (syndrome != '0) && !single_err;

    assign data_out = bypass ? data_in : (data_in ^ mask);
    assign sbit_err = bypass ? 1'b0 : single_err;
    assign dbit_err = bypass ? 1'b0 : double_err;

endmodule

// ==== source/ecc_store.sv ====
`timescale 1ns/1ns

module ecc_store
    import ecc_pkg::*;
#(
    parameter int ADDR_WIDTH = 4
)
(
    input  logic                  clk,
    input  logic                  en,
    input  logic                  we,
    input  logic [ADDR_WIDTH-1:0] addr,
    input  logic [CODE_W-1:0]     wdata,
    output logic [CODE_W-1:0]     rdata
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    logic [CODE_W-1:0] mem [DEPTH];

    // single port, the read word is registered and held until the next read.
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

// ==== source/ecc_ctrl.sv ====
`timescale 1ns/1ns

module ecc_ctrl
    import ecc_pkg::*;
#(
    parameter int ADDR_WIDTH = 4
)
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req,
    input  logic                  we,
    input  logic [ADDR_WIDTH-1:0] addr,
    input  logic [DATA_W-1:0]     wdata,
    input  logic [DATA_W-1:0]     inj_data,
    input  logic [PARITY_W-1:0]   inj_parity,
    input  logic                  bypass,
    input  logic                  scrub_en,
    input  logic [PARITY_W-1:0]   enc_parity,
    input  logic [DATA_W-1:0]     dec_data,
    input  logic                  dec_sbit,
    input  logic                  dec_dbit,
    output logic [DATA_W-1:0]     enc_data,
    output logic                  mem_en,
    output logic                  mem_we,
    output logic [ADDR_WIDTH-1:0] mem_addr,
    output logic [CODE_W-1:0]     mem_wdata,
    output logic                  dec_bypass,
    output logic                  chk_valid,
    output logic [ADDR_WIDTH-1:0] chk_addr,
    output logic                  rd_valid,
    output logic [DATA_W-1:0]     rdata,
    output logic                  sbit_err,
    output logic                  dbit_err
);

    scrub_state_t          state;
    logic [ADDR_WIDTH-1:0] scrub_addr;
    logic [DATA_W-1:0]     fix_data;
    logic                  scrub_rd;
    logic                  host_wr_hit;
    logic                  host_rd_q;
    logic                  scrub_rd_q;
    logic                  byp_q;
    logic [ADDR_WIDTH-1:0] rd_addr_q;

    // the host always owns the port when it asks for it.
    assign scrub_rd = !req && scrub_en && (state == S_READ);

    // a host write to the word under repair makes the held fix stale.
    assign host_wr_hit = req && we && (addr == scrub_addr);

    always_comb begin
        mem_en   = 1'b0;
        mem_we   = 1'b0;
        mem_addr = scrub_addr;
        enc_data = fix_data;
        if (req) begin
            mem_en   = 1'b1;
            mem_we   = we;
            mem_addr = addr;
            enc_data = wdata;
        end else if (scrub_rd) begin
            mem_en   = 1'b1;
        end else if (state == S_FIX) begin
            mem_en   = 1'b1;
            mem_we   = 1'b1;
        end
    end

    // fault masks only apply to host writes.
    assign mem_wdata = req ? {enc_parity ^ inj_parity, enc_data ^ inj_data}
                           : {enc_parity, enc_data};

    always_ff @(posedge clk) begin
        if (reset) begin
            host_rd_q  <= 1'b0;
            scrub_rd_q <= 1'b0;
            byp_q      <= 1'b0;
        end else begin
            host_rd_q  <= req && !we;
            scrub_rd_q <= scrub_rd;
            byp_q      <= req && !we && bypass;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_en && !mem_we) begin
            rd_addr_q <= mem_addr;
        end
    end

    assign dec_bypass = byp_q;
    assign chk_valid  = host_rd_q || scrub_rd_q;
    assign chk_addr   = rd_addr_q;

    assign rd_valid = host_rd_q;
    assign rdata    = dec_data;
    assign sbit_err = host_rd_q && dec_sbit;
    assign dbit_err = host_rd_q && dec_dbit;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= S_READ;
            scrub_addr <= '0;
        end else begin
            case (state)
                S_READ: begin
                    if (scrub_rd) begin
                        state <= S_CHECK;
                    end
                end
                S_CHECK: begin
                    if (dec_sbit && !host_wr_hit) begin
                        state <= S_FIX;
                    end else begin
                        state      <= S_READ;
                        scrub_addr <= scrub_addr + 1'b1;
                    end
                end
                S_FIX: begin
                    // either the fix is written or a host write replaced the word.
                    if (!req || host_wr_hit) begin
                        state      <= S_READ;
                        scrub_addr <= scrub_addr + 1'b1;
                    end
                end
                default: begin
                    state <= S_READ;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_CHECK) begin
            fix_data <= dec_data;
        end
    end

endmodule

// ==== source/ecc_err_log.sv ====
`timescale 1ns/1ns

module ecc_err_log
    import ecc_pkg::*;
#(
    parameter int ADDR_WIDTH = 4
)
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  chk_valid,
    input  logic [ADDR_WIDTH-1:0] chk_addr,
    input  logic                  dec_sbit,
    input  logic                  dec_dbit,
    output logic [COUNT_W-1:0]    sbit_count,
    output logic [COUNT_W-1:0]    dbit_count,
    output logic [ADDR_WIDTH-1:0] last_err_addr
);

    always_ff @(posedge clk) begin
        if (reset) begin
            sbit_count    <= '0;
            dbit_count    <= '0;
            last_err_addr <= '0;
        end else if (chk_valid) begin
            // counters stick at their maximum.
            if (dec_sbit && (sbit_count != '1)) begin
                sbit_count <= sbit_count + 1'b1;
            end
            if (dec_dbit && (dbit_count != '1)) begin
                dbit_count <= dbit_count + 1'b1;
            end
            if (dec_sbit || dec_dbit) begin
                last_err_addr <= chk_addr;
            end
        end
    end

endmodule

// ==== source/ecc_mem_top.sv ====
`timescale 1ns/1ns

module ecc_mem_top
    import ecc_pkg::*;
#(
    parameter int ADDR_WIDTH = 4
)
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req,
    input  logic                  we,
    input  logic [ADDR_WIDTH-1:0] addr,
    input  logic [DATA_W-1:0]     wdata,
    input  logic [DATA_W-1:0]     inj_data,
    input  logic [PARITY_W-1:0]   inj_parity,
    input  logic                  bypass,
    input  logic                  scrub_en,
    output logic                  rd_valid,
    output logic [DATA_W-1:0]     rdata,
    output logic                  sbit_err,
    output logic                  dbit_err,
    output logic [COUNT_W-1:0]    sbit_count,
    output logic [COUNT_W-1:0]    dbit_count,
    output logic [ADDR_WIDTH-1:0] last_err_addr
);

    logic [DATA_W-1:0]     enc_data;
    logic [PARITY_W-1:0]   enc_parity;
    logic                  mem_en;
    logic                  mem_we;
    logic [ADDR_WIDTH-1:0] mem_addr;
    logic [CODE_W-1:0]     mem_wdata;
    logic [CODE_W-1:0]     mem_rdata;
    logic                  dec_bypass;
    logic [DATA_W-1:0]     dec_data;
    logic                  dec_sbit;
    logic                  dec_dbit;
    logic                  chk_valid;
    logic [ADDR_WIDTH-1:0] chk_addr;

    ecc_ctrl #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .we         (we),
        .addr       (addr),
        .wdata      (wdata),
        .inj_data   (inj_data),
        .inj_parity (inj_parity),
        .bypass     (bypass),
        .scrub_en   (scrub_en),
        .enc_parity (enc_parity),
        .dec_data   (dec_data),
        .dec_sbit   (dec_sbit),
        .dec_dbit   (dec_dbit),
        .enc_data   (enc_data),
        .mem_en     (mem_en),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .dec_bypass (dec_bypass),
        .chk_valid  (chk_valid),
        .chk_addr   (chk_addr),
        .rd_valid   (rd_valid),
        .rdata      (rdata),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

    // write path encoder, only its check bits are used.
    ecc_65_cal u_enc (
        .data_in    (enc_data),
        .parity_in  ('0),
        .bypass     (1'b0),
        .data_out   (),
        .parity_out (enc_parity),
        .mask       (),
        .sbit_err   (),
        .dbit_err   ()
    );

    ecc_store #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_store (
        .clk   (clk),
        .en    (mem_en),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

    // read path checker on the word out of the store.
    ecc_65_cal u_dec (
        .data_in    (mem_rdata[DATA_W-1:0]),
        .parity_in  (mem_rdata[CODE_W-1:DATA_W]),
        .bypass     (dec_bypass),
        .data_out   (dec_data),
        .parity_out (),
        .mask       (),
        .sbit_err   (dec_sbit),
        .dbit_err   (dec_dbit)
    );

    ecc_err_log #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_log (
        .clk           (clk),
        .reset         (reset),
        .chk_valid     (chk_valid),
        .chk_addr      (chk_addr),
        .dec_sbit      (dec_sbit),
        .dec_dbit      (dec_dbit),
        .sbit_count    (sbit_count),
        .dbit_count    (dbit_count),
        .last_err_addr (last_err_addr)
    );

endmodule

// ==== sim/ecc_mem_tb.sv ====
`timescale 1ns/1ns

module ecc_mem_tb
    import ecc_pkg::*;
;

    localparam int ADDR_WIDTH = 4;
    localparam int DEPTH      = 2 ** ADDR_WIDTH;
    localparam int MAX_CYCLES = 2000;

    logic                  clk;
    logic                  reset;
    logic                  req;
    logic                  we;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_W-1:0]     wdata;
    logic [DATA_W-1:0]     inj_data;
    logic [PARITY_W-1:0]   inj_parity;
    logic                  bypass;
    logic                  scrub_en;
    logic                  rd_valid;
    logic [DATA_W-1:0]     rdata;
    logic                  sbit_err;
    logic                  dbit_err;
    logic [COUNT_W-1:0]    sbit_count;
    logic [COUNT_W-1:0]    dbit_count;
    logic [ADDR_WIDTH-1:0] last_err_addr;

    logic [15:0]           lfsr_state = 16'd49149;
    logic [DATA_W-1:0]     shadow [DEPTH];
    logic [DATA_W-1:0]     inj_mem [DEPTH];
    int                    cycle_count = 0;

    ecc_mem_top #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_dut (
        .clk           (clk),
        .reset         (reset),
        .req           (req),
        .we            (we),
        .addr          (addr),
        .wdata         (wdata),
        .inj_data      (inj_data),
        .inj_parity    (inj_parity),
        .bypass        (bypass),
        .scrub_en      (scrub_en),
        .rd_valid      (rd_valid),
        .rdata         (rdata),
        .sbit_err      (sbit_err),
        .dbit_err      (dbit_err),
        .sbit_count    (sbit_count),
        .dbit_count    (dbit_count),
        .last_err_addr (last_err_addr)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count == MAX_CYCLES);
        $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
        $display("=== FAIL ===");
        $fatal(1);
    end

    // a host read at one edge gives rd_valid in the following cycle only.
    rd_after_req: assert property (@(posedge clk) disable iff (reset)
        (req && !we) |=> rd_valid)
    else begin
        $display("rd_valid did not follow a host read one cycle later");
        $display("=== FAIL ===");
        $fatal(1);
    end

    rd_only_after_req: assert property (@(posedge clk) disable iff (reset)
        rd_valid |-> $past(req && !we))
    else begin
        $display("rd_valid was raised without a host read in the cycle before");
        $display("=== FAIL ===");
        $fatal(1);
    end

    // taps 16, 14, 13 and 11.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic take_bits(input int n, output logic [DATA_W-1:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[DATA_W-2:0], lfsr_state[0]};
        end
    endtask

    task automatic check_value(input string test, input string what,
                               input logic [DATA_W-1:0] exp, input logic [DATA_W-1:0] act);
        assert (act === exp)
        else begin
            $display("mismatch %s %s expected %0h actual %0h", test, what, exp, act);
            $display("=== FAIL ===");
            $fatal(1);
        end
    endtask

    task automatic check_at_least(input string test, input string what,
                                  input int min, input int act);
        assert (act >= min)
        else begin
            $display("mismatch %s %s expected at least %0d actual %0d", test, what, min, act);
            $display("=== FAIL ===");
            $fatal(1);
        end
    endtask

    // every task starts and ends a short delay after a rising edge.
    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
        #10;
    endtask

    task automatic write_word(input logic [ADDR_WIDTH-1:0] a, input logic [DATA_W-1:0] d,
                              input logic [DATA_W-1:0] mi, input logic [PARITY_W-1:0] mp);
        req        = 1'b1;
        we         = 1'b1;
        addr       = a;
        wdata      = d;
        inj_data   = mi;
        inj_parity = mp;
        shadow[a]  = d;
        inj_mem[a] = mi;
        idle_cycles(1);
        req        = 1'b0;
        we         = 1'b0;
        inj_data   = '0;
        inj_parity = '0;
    endtask

    task automatic read_expect(input string test, input logic [ADDR_WIDTH-1:0] a,
                               input logic byp, input logic check_data,
                               input logic [DATA_W-1:0] exp_data,
                               input logic exp_s, input logic exp_d);
        req    = 1'b1;
        we     = 1'b0;
        addr   = a;
        bypass = byp;
        idle_cycles(1);
        req    = 1'b0;
        bypass = 1'b0;
        check_value(test, "rd_valid", 1, rd_valid);
        if (check_data) begin
            check_value(test, "rdata", exp_data, rdata);
        end
        check_value(test, "sbit_err", exp_s, sbit_err);
        check_value(test, "dbit_err", exp_d, dbit_err);
    endtask

    initial begin
        logic [DATA_W-1:0] v;
        logic [DATA_W-1:0] d;
        logic [DATA_W-1:0] m;
        int                pos;
        int                pos2;
        int                exp_sbit;
        int                exp_dbit;
        reset      = 1'b1;
        req        = 1'b0;
        we         = 1'b0;
        addr       = '0;
        wdata      = '0;
        inj_data   = '0;
        inj_parity = '0;
        bypass     = 1'b0;
        scrub_en   = 1'b0;
        repeat (2) @(posedge clk);
        #10;
        reset = 1'b0;

        check_value("clean", "rd_valid", 0, rd_valid);
        check_value("clean", "sbit_err", 0, sbit_err);
        check_value("clean", "dbit_err", 0, dbit_err);
        check_value("clean", "sbit_count", 0, sbit_count);
        check_value("clean", "dbit_count", 0, dbit_count);
        check_value("clean", "last_err_addr", 0, last_err_addr);
        for (int i = 0; i < DEPTH; i++) begin
            take_bits(DATA_W, d);
            write_word(i, d, '0, '0);
        end
        for (int i = 0; i < DEPTH; i++) begin
            read_expect("clean", i, 1'b0, 1'b1, shadow[i], 1'b0, 1'b0);
        end
        idle_cycles(1);
        check_value("clean", "sbit_count", 0, sbit_count);
        check_value("clean", "dbit_count", 0, dbit_count);
        exp_sbit = 0;
        exp_dbit = 0;

        take_bits(DATA_W, d);
        take_bits(7, v);
        pos = v % DATA_W;
        m = '0;
        m[pos] = 1'b1;
        write_word(3, d, m, '0);
        read_expect("single_data", 3, 1'b0, 1'b1, d, 1'b1, 1'b0);
        idle_cycles(1);
        exp_sbit++;
        check_value("single_data", "sbit_count", exp_sbit, sbit_count);
        check_value("single_data", "last_err_addr", 3, last_err_addr);

        take_bits(DATA_W, d);
        take_bits(3, v);
        write_word(5, d, '0, 8'd1 << v[2:0]);
        read_expect("single_parity", 5, 1'b0, 1'b1, d, 1'b1, 1'b0);
        idle_cycles(1);
        exp_sbit++;
        check_value("single_parity", "sbit_count", exp_sbit, sbit_count);
        check_value("single_parity", "last_err_addr", 5, last_err_addr);

        // the second position is shifted by 1 to 64 so the two bits differ.
        take_bits(DATA_W, d);
        take_bits(7, v);
        pos = v % DATA_W;
        take_bits(6, v);
        pos2 = (pos + 1 + v % 64) % DATA_W;
        m = '0;
        m[pos] = 1'b1;
        m[pos2] = 1'b1;
        write_word(7, d, m, '0);
        read_expect("double", 7, 1'b0, 1'b0, '0, 1'b0, 1'b1);
        idle_cycles(1);
        exp_dbit++;
        check_value("double", "dbit_count", exp_dbit, dbit_count);
        check_value("double", "last_err_addr", 7, last_err_addr);

        read_expect("bypass", 3, 1'b1, 1'b1, shadow[3] ^ inj_mem[3], 1'b0, 1'b0);
        idle_cycles(1);
        check_value("bypass", "sbit_count", exp_sbit, sbit_count);
        check_value("bypass", "dbit_count", exp_dbit, dbit_count);

        // addresses 3 and 5 still hold single errors, so six words need repair.
        for (int i = 8; i < 12; i++) begin
            take_bits(DATA_W, d);
            take_bits(7, v);
            pos = v % DATA_W;
            m = '0;
            m[pos] = 1'b1;
            write_word(i, d, m, '0);
        end
        scrub_en = 1'b1;
        idle_cycles(60);
        scrub_en = 1'b0;
        idle_cycles(4);
        check_at_least("scrub", "sbit_count", exp_sbit + 6, sbit_count);
        // a full pass takes at most 48 cycles, so the double error at 7 was seen at least once.
        check_at_least("scrub", "dbit_count", exp_dbit + 1, dbit_count);
        read_expect("scrub", 3, 1'b0, 1'b1, shadow[3], 1'b0, 1'b0);
        read_expect("scrub", 5, 1'b0, 1'b1, shadow[5], 1'b0, 1'b0);
        for (int i = 8; i < 12; i++) begin
            read_expect("scrub", i, 1'b0, 1'b1, shadow[i], 1'b0, 1'b0);
        end
        read_expect("scrub", 7, 1'b0, 1'b0, '0, 1'b0, 1'b1);
        idle_cycles(1);
        check_at_least("scrub", "dbit_count", exp_dbit + 2, dbit_count);
        check_value("scrub", "last_err_addr", 7, last_err_addr);

        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== ecc_mem_top.f ====
source/ecc_pkg.sv
source/ecc_65_cal.sv
source/ecc_store.sv
source/ecc_ctrl.sv
source/ecc_err_log.sv
source/ecc_mem_top.sv
sim/ecc_mem_tb.sv
